// File: hdl/core_uarch_pkg.sv
`default_nettype none

package core_uarch_pkg;

	//////////////////////////////
	// Basic types
	//////////////////////////////

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// One bit per control cycle. Exactly one of them is set at any time.
	typedef struct packed {
		logic issue;
		logic transfer;
		logic base_writeback;
		logic mul;
		logic mul_hi_wb;
		logic exception;
		logic idle;
	} ctrl_cycle;

	typedef enum logic [2:0] {
		op_alu,
		op_ldm,
		op_stm,
		op_mull,
		op_swi
	} op_kind;

	//////////////////////////////
	// Fixed registers and vectors
	//////////////////////////////

	localparam reg_num r14 = 4'd14;
	localparam reg_num r15 = 4'd15;

	localparam word vector_swi = 32'h0000_0008;

endpackage

`default_nettype wire

// File: hdl/core_control_cycle.sv
`default_nettype none

module core_control_cycle import core_uarch_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      issue,
	input  op_kind    kind,
	input  reg_num    insn_rn,
	input  logic      insn_base_wb,
	input  logic      mem_ready,
	input  logic      list_empty,

	output ctrl_cycle cycle,
	output ctrl_cycle next_cycle,
	output word       saved_base,
	output reg_num    ra,
	output reg_num    mul_r_add_hi,
	output logic      ldst_next,
	output logic      mem_write,
	output logic      load_list,
	output logic      busy
);

	op_kind kind_q;
	reg_num rn_q;
	logic   base_wb_q;
	logic   drain;

	// A new instruction is only taken while the sequencer rests.
	assign load_list = issue && cycle.idle;
	assign ldst_next = cycle.transfer;

	assign ra = rn_q;
	assign mul_r_add_hi = rn_q;

	// Busy covers one extra cycle so that the delayed flag write lands first.
	assign busy = !cycle.idle || drain;

	always_comb begin
		next_cycle = '0;
		if (cycle.idle) begin
			if (issue)
				next_cycle.issue = 1'b1;
			else
				next_cycle.idle = 1'b1;
		end else if (cycle.issue) begin
			case (kind_q)
				op_ldm, op_stm: next_cycle.transfer = 1'b1;
				op_mull:        next_cycle.mul = 1'b1;
				op_swi:         next_cycle.exception = 1'b1;
				default:        next_cycle.idle = 1'b1;
			endcase
		end else if (cycle.transfer) begin
			if (!list_empty)
				next_cycle.transfer = 1'b1;
			else if (base_wb_q)
				next_cycle.base_writeback = 1'b1;
			else
				next_cycle.idle = 1'b1;
		end else if (cycle.mul)
			next_cycle.mul_hi_wb = 1'b1;
		else if (cycle.exception)
			// The return address is written from the issue cycle that follows.
			next_cycle.issue = 1'b1;
		else
			next_cycle.idle = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= '{idle: 1'b1, default: 1'b0};
			kind_q <= op_alu;
			rn_q <= '0;
			base_wb_q <= 1'b0;
			mem_write <= 1'b0;
			drain <= 1'b0;
			saved_base <= '0;
		end else begin
			cycle <= next_cycle;
			drain <= !cycle.idle;

			if (load_list) begin
				kind_q <= kind;
				rn_q <= insn_rn;
				base_wb_q <= insn_base_wb;
				mem_write <= (kind == op_stm);
				saved_base <= '0;
			end else if (cycle.exception)
				kind_q <= op_alu;

			// Byte offset from the base. It grows by one word per completed transfer.
			if (ldst_next && mem_ready && !list_empty)
				saved_base <= saved_base + 32'd4;

			if (next_cycle.idle)
				mem_write <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) $onehot(next_cycle))
		else $error("next_cycle is not one-hot");

endmodule

`default_nettype wire

// File: hdl/core_reg_list_pop.sv
`default_nettype none

module core_reg_list_pop import core_uarch_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        load_list,
	input  logic [15:0] reg_list,
	input  logic        ldst_next,
	input  logic        mem_ready,

	output reg_num      popped,
	output logic        pop_valid,
	output logic        list_empty
);

	logic [15:0] remaining;

	assign list_empty = (remaining == '0);
	assign pop_valid = ldst_next && !list_empty;

	// Lowest set bit wins.
	always_comb begin
		popped = '0;
		for (int i = 15; i >= 0; i--)
			if (remaining[i])
				popped = reg_num'(i);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			remaining <= '0;
		else if (load_list)
			remaining <= reg_list;
		else if (pop_valid && mem_ready)
			remaining <= remaining & (remaining - 16'd1);
	end

	// A pop clears exactly the bit of the register that was presented.
	assert property (@(posedge clk) disable iff (!rst_n)
		pop_valid && mem_ready && !load_list
		|=> remaining == ($past(remaining) & ~(16'd1 << $past(popped))))
		else $error("a pop cleared a bit other than the popped register");

endmodule

`default_nettype wire

// File: hdl/core_control_writeback.sv
`default_nettype none

module core_control_writeback import core_uarch_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  reg_num    dec_rd,
	input  logic      dec_writeback,
	input  logic      dec_update_flags,
	input  psr_flags  alu_flags,
	input  word       q_alu,
	input  word       ldst_read,
	input  logic      mem_ready,
	input  logic      mem_write,
	input  word       mul_q_hi,
	input  word       mul_q_lo,

	input  ctrl_cycle cycle,
	input  ctrl_cycle next_cycle,
	input  word       saved_base,
	input  word       vector,
	input  reg_num    ra,
	input  reg_num    popped,
	input  reg_num    mul_r_add_hi,
	input  logic      issue,
	input  logic      pop_valid,
	input  logic      ldst_next,

	output reg_num    rd,
	output reg_num    final_rd,
	output logic      writeback,
	output logic      final_writeback,
	output logic      update_flags,
	output logic      final_update_flags,
	output word       wr_value,
	output psr_flags  wb_alu_flags
);

	reg_num last_rd;
	logic   take_insn;
	logic   alu_done;

	assign take_insn = next_cycle.issue && cycle.idle;

	// Only an issue cycle that falls back to idle completes a plain ALU op.
	assign alu_done = cycle.issue && next_cycle.idle;

	//////////////////////////////
	// Write port selection
	//////////////////////////////

	always_comb begin
		rd = last_rd;
		writeback = 1'b0;
		wr_value = saved_base;

		if (cycle.transfer) begin
			rd = popped;
			writeback = ldst_next && mem_ready && pop_valid && !mem_write;
			wr_value = ldst_read;
		end else if (cycle.base_writeback) begin
			rd = ra;
			writeback = !mem_write;
			wr_value = ldst_read;
		end else if (cycle.mul) begin
			rd = final_rd;
			writeback = 1'b1;
			wr_value = mul_q_lo;
		end else if (cycle.mul_hi_wb) begin
			rd = mul_r_add_hi;
			writeback = 1'b1;
			wr_value = mul_q_hi;
		end else if (cycle.exception) begin
			rd = r15;
			writeback = 1'b1;
			wr_value = vector;
		end else if (alu_done) begin
			rd = final_rd;
			writeback = final_writeback;
			wr_value = q_alu;
		end
	end

	//////////////////////////////
	// Shadow registers
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_rd <= '0;
			final_rd <= '0;
			final_writeback <= 1'b0;
			update_flags <= 1'b0;
			final_update_flags <= 1'b0;
			wb_alu_flags <= '0;
		end else begin
			last_rd <= rd;
			wb_alu_flags <= alu_flags;

			if (take_insn)
				final_rd <= dec_rd;
			else if (next_cycle.exception)
				final_rd <= r14;

			if (take_insn)
				final_writeback <= issue && dec_writeback;
			else if (next_cycle.exception)
				final_writeback <= 1'b1;

			update_flags <= alu_done && final_update_flags;

			// An exception never touches the flags.
			if (take_insn)
				final_update_flags <= issue && dec_update_flags;
			else if (next_cycle.exception)
				final_update_flags <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		cycle.exception |=> !update_flags ##1 !update_flags)
		else $error("flag update after a software interrupt");

endmodule

`default_nettype wire

// File: hdl/core_reg_file.sv
`default_nettype none

module core_reg_file import core_uarch_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	input  logic     writeback,
	input  reg_num   rd,
	input  word      wr_value,
	input  logic     update_flags,
	input  psr_flags wb_alu_flags,
	input  reg_num   dbg_addr,

	output word      dbg_data,
	output psr_flags flags
);

	word regs [16];

	assign dbg_data = regs[dbg_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (writeback)
			regs[rd] <= wr_value;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			flags <= '0;
		else if (update_flags)
			flags <= wb_alu_flags;
	end

	assert property (@(posedge clk) disable iff (!rst_n) writeback |-> !$isunknown(rd))
		else $error("write with unknown destination register");

endmodule

`default_nettype wire

// File: hdl/core_writeback_unit.sv
`default_nettype none

module core_writeback_unit import core_uarch_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        issue,
	input  op_kind      kind,
	input  reg_num      insn_rd,
	input  reg_num      insn_rn,
	input  logic        insn_writeback,
	input  logic        insn_update_flags,
	input  logic        insn_base_wb,
	input  logic [15:0] reg_list,

	input  word         alu_result,
	input  psr_flags    alu_flags,
	input  word         mul_q_hi,
	input  word         mul_q_lo,

	input  logic        mem_ready,
	input  word         mem_read_data,

	output logic        busy,
	input  reg_num      dbg_addr,
	output word         dbg_data,
	output psr_flags    flags
);

	ctrl_cycle cycle;
	ctrl_cycle next_cycle;
	word       saved_base;
	reg_num    ra;
	reg_num    mul_r_add_hi;
	logic      ldst_next;
	logic      mem_write;
	logic      load_list;

	reg_num    popped;
	logic      pop_valid;
	logic      list_empty;

	reg_num    rd;
	logic      writeback;
	word       wr_value;
	logic      update_flags;
	psr_flags  wb_alu_flags;

	core_control_cycle u_cycle (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue),
		.kind         (kind),
		.insn_rn      (insn_rn),
		.insn_base_wb (insn_base_wb),
		.mem_ready    (mem_ready),
		.list_empty   (list_empty),
		.cycle        (cycle),
		.next_cycle   (next_cycle),
		.saved_base   (saved_base),
		.ra           (ra),
		.mul_r_add_hi (mul_r_add_hi),
		.ldst_next    (ldst_next),
		.mem_write    (mem_write),
		.load_list    (load_list),
		.busy         (busy)
	);

	core_reg_list_pop u_pop (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_list  (load_list),
		.reg_list   (reg_list),
		.ldst_next  (ldst_next),
		.mem_ready  (mem_ready),
		.popped     (popped),
		.pop_valid  (pop_valid),
		.list_empty (list_empty)
	);

	core_control_writeback u_writeback (
		.clk                (clk),
		.rst_n              (rst_n),
		.dec_rd             (insn_rd),
		.dec_writeback      (insn_writeback),
		.dec_update_flags   (insn_update_flags),
		.alu_flags          (alu_flags),
		.q_alu              (alu_result),
		.ldst_read          (mem_read_data),
		.mem_ready          (mem_ready),
		.mem_write          (mem_write),
		.mul_q_hi           (mul_q_hi),
		.mul_q_lo           (mul_q_lo),
		.cycle              (cycle),
		.next_cycle         (next_cycle),
		.saved_base         (saved_base),
		.vector             (vector_swi),
		.ra                 (ra),
		.popped             (popped),
		.mul_r_add_hi       (mul_r_add_hi),
		.issue              (issue),
		.pop_valid          (pop_valid),
		.ldst_next          (ldst_next),
		.rd                 (rd),
		.final_rd           (),
		.writeback          (writeback),
		.final_writeback    (),
		.update_flags       (update_flags),
		.final_update_flags (),
		.wr_value           (wr_value),
		.wb_alu_flags       (wb_alu_flags)
	);

	core_reg_file u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.writeback    (writeback),
		.rd           (rd),
		.wr_value     (wr_value),
		.update_flags (update_flags),
		.wb_alu_flags (wb_alu_flags),
		.dbg_addr     (dbg_addr),
		.dbg_data     (dbg_data),
		.flags        (flags)
	);

endmodule

`default_nettype wire

// File: tb/core_writeback_unit_tb.sv
`default_nettype none

module core_writeback_unit_tb import core_uarch_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// A transfer lasts at most this many cycles. The last of them has mem_ready high.
	localparam int max_stall = 4;

	localparam int n_alu = 40;
	localparam int n_flags = 30;
	localparam int n_ldst = 20;
	localparam int n_ldm_wb = 12;
	localparam int n_mull = 16;
	localparam int n_swi = 8;
	localparam int total_insns = n_alu + n_flags + n_ldst + n_ldm_wb + n_mull + n_swi;

	// The readback of all registers adds 17 cycles per instruction. The margin covers it.
	localparam int cycle_limit = total_insns * (2 + 16 * max_stall) + total_insns * 24 + 200;

	logic        clk;
	logic        rst_n;
	logic        issue;
	op_kind      kind;
	reg_num      insn_rd;
	reg_num      insn_rn;
	logic        insn_writeback;
	logic        insn_update_flags;
	logic        insn_base_wb;
	logic [15:0] reg_list;
	word         alu_result;
	psr_flags    alu_flags;
	word         mul_q_hi;
	word         mul_q_lo;
	logic        mem_ready;
	word         mem_read_data;
	logic        busy;
	reg_num      dbg_addr;
	word         dbg_data;
	psr_flags    flags;

	word         model_regs [16];
	psr_flags    model_flags;
	word         ld_vals [16];
	logic [31:0] lfsr_state;
	string       insn_text;
	int          checks;
	int          errors;
	int          cycle_count;
	event        compare_start;
	event        compare_done;

	core_writeback_unit i_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.issue             (issue),
		.kind              (kind),
		.insn_rd           (insn_rd),
		.insn_rn           (insn_rn),
		.insn_writeback    (insn_writeback),
		.insn_update_flags (insn_update_flags),
		.insn_base_wb      (insn_base_wb),
		.reg_list          (reg_list),
		.alu_result        (alu_result),
		.alu_flags         (alu_flags),
		.mul_q_hi          (mul_q_hi),
		.mul_q_lo          (mul_q_lo),
		.mem_ready         (mem_ready),
		.mem_read_data     (mem_read_data),
		.busy              (busy),
		.dbg_addr          (dbg_addr),
		.dbg_data          (dbg_data),
		.flags             (flags)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Random numbers
	//////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		return take_bits(1) == 32'd1;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic void apply_insn(input op_kind k, input reg_num rd, input reg_num rn,
			input logic wb, input logic uf, input logic bwb, input logic [15:0] list,
			input word alu_res, input psr_flags aflags, input word q_hi, input word q_lo,
			input word base_value);
		int n;
		n = 0;
		case (k)
			op_alu: begin
				if (wb)
					model_regs[rd] = alu_res;
				if (uf)
					model_flags = aflags;
			end
			op_ldm: begin
				// Registers fill in ascending order from the ready beats.
				for (int i = 0; i < 16; i++) begin
					if (list[i]) begin
						model_regs[i] = ld_vals[n];
						n++;
					end
				end
				if (bwb)
					model_regs[rn] = base_value;
			end
			op_mull: begin
				model_regs[rd] = q_lo;
				model_regs[rn] = q_hi;
			end
			op_swi: begin
				model_regs[r15] = vector_swi;
				model_regs[r14] = alu_res;
			end
			default: begin
			end
		endcase
	endfunction

	//////////////////////////////
	// Instruction driver
	//////////////////////////////

	task automatic drive_insn(input op_kind k, input reg_num rd, input reg_num rn, input logic wb,
			input logic uf, input logic bwb, input logic [15:0] list);
		word      alu_res;
		psr_flags aflags;
		word      q_hi;
		word      q_lo;
		word      base_value;
		word      data;
		logic     ready;
		int       needed;
		int       delivered;
		int       low_run;

		alu_res = take_bits(32);
		aflags = 4'(take_bits(4));
		q_hi = take_bits(32);
		q_lo = take_bits(32);
		base_value = take_bits(32);
		needed = (k == op_ldm || k == op_stm) ? $countones(list) : 0;
		delivered = 0;
		low_run = 0;
		insn_text = $sformatf("%s rd=%0d rn=%0d wb=%0b uf=%0b base_wb=%0b list=%h",
			k.name(), rd, rn, wb, uf, bwb, list);

		@(posedge clk);
		issue <= 1'b1;
		kind <= k;
		insn_rd <= rd;
		insn_rn <= rn;
		insn_writeback <= wb;
		insn_update_flags <= uf;
		insn_base_wb <= bwb;
		reg_list <= list;
		alu_result <= alu_res;
		alu_flags <= aflags;
		mul_q_hi <= q_hi;
		mul_q_lo <= q_lo;
		mem_ready <= 1'b0;

		// The issue cycle follows this edge and takes no memory beat.
		@(posedge clk);
		issue <= 1'b0;

		// The sequencer has left idle once it took the instruction.
		@(negedge clk);
		checks++;
		assert (busy === 1'b1) else begin
			errors++;
			$display("CHECK FAILED at %0t: busy is low in the issue cycle of %s",
				$time, insn_text);
		end

		do begin
			@(posedge clk);
			if (delivered < needed) begin
				ready = rand_bit();
				if (low_run == max_stall - 1)
					ready = 1'b1;
				data = take_bits(32);
				mem_ready <= ready;
				mem_read_data <= data;
				if (ready) begin
					ld_vals[delivered] = data;
					delivered++;
					low_run = 0;
				end else begin
					low_run++;
				end
			end else begin
				// After the last beat the bus holds the value meant for the base register.
				mem_ready <= rand_bit();
				mem_read_data <= base_value;
			end
			@(negedge clk);
		end while (busy);

		apply_insn(k, rd, rn, wb, uf, bwb, list, alu_res, aflags, q_hi, q_lo, base_value);
		-> compare_start;
		@(compare_done);
	endtask

	task automatic run_test(input int id, input string name, input int count);
		int          first_checks;
		int          first_errors;
		op_kind      k;
		reg_num      rd;
		reg_num      rn;
		logic        wb;
		logic        uf;
		logic        bwb;
		logic [15:0] list;

		first_checks = checks;
		first_errors = errors;
		for (int n = 0; n < count; n++) begin
			rd = reg_num'(take_bits(4));
			rn = reg_num'(take_bits(4));
			k = op_alu;
			wb = 1'b0;
			uf = 1'b0;
			bwb = 1'b0;
			list = '0;
			case (id)
				1: wb = rand_bit();
				2: begin
					wb = rand_bit();
					uf = rand_bit();
				end
				3: begin
					k = rand_bit() ? op_ldm : op_stm;
					list = 16'(take_bits(16));
				end
				4: begin
					k = op_ldm;
					bwb = 1'b1;
					list = 16'(take_bits(16));
				end
				5: begin
					k = op_mull;
					uf = rand_bit();
				end
				default: begin
					k = op_swi;
					uf = rand_bit();
				end
			endcase
			drive_insn(k, rd, rn, wb, uf, bwb, list);
		end
		$display("Test %0d %s: %0d instructions, %0d checks, %0d errors", id, name, count,
			checks - first_checks, errors - first_errors);
	endtask

	//////////////////////////////
	// Compare process
	//////////////////////////////

	initial begin
		checks = 0;
		errors = 0;
		dbg_addr <= '0;
		forever begin
			@(compare_start);
			for (int i = 0; i < 16; i++) begin
				@(posedge clk);
				dbg_addr <= reg_num'(i);
				@(negedge clk);
				checks++;
				assert (dbg_data === model_regs[i]) else begin
					errors++;
					$display("CHECK FAILED at %0t: r%0d is %h, expected %h after %s",
						$time, i, dbg_data, model_regs[i], insn_text);
				end
			end
			checks++;
			assert (flags === model_flags) else begin
				errors++;
				$display("CHECK FAILED at %0t: flags are %b, expected %b after %s",
					$time, flags, model_flags, insn_text);
			end
			-> compare_done;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Something failed");
		$finish;
	end

	initial begin
		rst_n <= 1'b0;
		issue <= 1'b0;
		kind <= op_alu;
		insn_rd <= '0;
		insn_rn <= '0;
		insn_writeback <= 1'b0;
		insn_update_flags <= 1'b0;
		insn_base_wb <= 1'b0;
		reg_list <= '0;
		alu_result <= '0;
		alu_flags <= '0;
		mul_q_hi <= '0;
		mul_q_lo <= '0;
		mem_ready <= 1'b0;
		mem_read_data <= '0;
		lfsr_state = 32'heaad9172;
		model_flags = '0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		run_test(1, "alu_writes", n_alu);
		run_test(2, "alu_flags", n_flags);
		run_test(3, "load_store_multiple", n_ldst);
		run_test(4, "load_multiple_base_writeback", n_ldm_wb);
		run_test(5, "long_multiply", n_mull);
		run_test(6, "software_interrupt", n_swi);

		$display("Summary: 6 tests, %0d instructions, %0d checks, %0d errors",
			total_insns, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: core_writeback_unit.f
hdl/core_uarch_pkg.sv
hdl/core_control_cycle.sv
hdl/core_reg_list_pop.sv
hdl/core_control_writeback.sv
hdl/core_reg_file.sv
hdl/core_writeback_unit.sv
tb/core_writeback_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module core_writeback_unit_tb -f core_writeback_unit.f \
	&& ./obj_dir/Vcore_writeback_unit_tb | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
